// File: encoder_pkg.sv
`default_nettype none

package encoder_pkg;

  // counts are decimal, 0 to 9999, so 14 bits are enough.
  localparam int count_w = 14;

  // iteration counter width for anything that walks the count bit by bit.
  localparam int count_idx_w = $clog2(count_w);

  // two flops per asynchronous input.
  localparam int sync_stages = 2;

  typedef logic [count_w-1:0] count_t;

  // up from count_max wraps to 0, down from 0 wraps to count_max.
  localparam count_t count_max = count_t'(9999);

endpackage

`default_nettype wire

// File: display_pkg.sv
`default_nettype none

package display_pkg;

  localparam int num_digits = 8;
  localparam int digits_per_channel = 4;

  // clock cycles per digit slot, longer than one serial frame.
  localparam int scan_period = 64;

  // clock cycles per sck phase.
  localparam int sck_half = 1;

  // select byte followed by segment byte.
  localparam int frame_bits = 16;

  localparam int scan_cnt_w = $clog2(scan_period);
  localparam int digit_idx_w = $clog2(num_digits);
  localparam int sck_cnt_w = $clog2(sck_half + 1);
  localparam int frame_idx_w = $clog2(frame_bits);

  typedef logic [3:0] bcd_t;
  typedef logic [15:0] bcd_word_t;
  typedef logic [7:0] seg_t;
  typedef logic [7:0] sel_t;

  // bit 0 is segment a, bit 6 is g, bit 7 (dp) stays low.
  localparam seg_t seg_font [10] = '{
    8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66,
    8'h6d, 8'h7d, 8'h07, 8'h7f, 8'h6f
  };

endpackage

`default_nettype wire

// File: quad_decoder.sv
`default_nettype none

module quad_decoder
  import encoder_pkg::*;
(
  input  wire    clk,
  input  wire    reset,
  input  wire    a,
  input  wire    b,
  input  wire    clear,
  output count_t count
);

  logic [sync_stages-1:0] a_sync;
  logic [sync_stages-1:0] b_sync;
  logic [sync_stages-1:0] clear_sync;
  logic [1:0] phase;
  logic [1:0] prev_phase;
  logic [1:0] change;
  logic step;
  logic up;

  assign phase = {a_sync[sync_stages-1], b_sync[sync_stages-1]};
  assign change = phase ^ prev_phase;

  // a step is a change of exactly one phase bit; a double change is a glitch.
  assign step = change[1] ^ change[0];

  // with A leading B the sequence is 00, 10, 11, 01, so the new A differs
  // from the old B on every forward step.
  assign up = phase[1] ^ prev_phase[0];

  always_ff @(posedge clk) begin
    if (reset) begin
      a_sync <= '0;
      b_sync <= '0;
      clear_sync <= '0;
      prev_phase <= 2'b00;
    end else begin
      a_sync <= {a_sync[sync_stages-2:0], a};
      b_sync <= {b_sync[sync_stages-2:0], b};
      clear_sync <= {clear_sync[sync_stages-2:0], clear};
      prev_phase <= phase;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (clear_sync[sync_stages-1]) begin
      // clear wins over any step seen in the same cycle.
      count <= '0;
    end else if (step) begin
      if (up) begin
        if (count == count_max) begin
          count <= '0;
        end else begin
          count <= count + 1'b1;
        end
      end else begin
        if (count == '0) begin
          count <= count_max;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: bin_to_bcd.sv
`default_nettype none

module bin_to_bcd
  import encoder_pkg::*;
  import display_pkg::*;
(
  input  wire       clk,
  input  wire       reset,
  input  wire count_t count_1,
  input  wire count_t count_2,
  output logic      bcd_valid,
  output logic      bcd_channel,
  output bcd_word_t bcd_word
);

  typedef enum logic [1:0] {idle_load, shift, done} state_t;

  state_t state;
  logic channel;
  logic [count_idx_w-1:0] iter;
  count_t bin_reg;
  bcd_word_t bcd_reg;
  bcd_word_t bcd_adj;

  // add 3 to every digit of 5 or more before the next shift.
  always_comb begin
    bcd_adj = bcd_reg;
    for (int i = 0; i < digits_per_channel; i++) begin
      if (bcd_reg[4*i +: 4] > 4'd4) begin
        bcd_adj[4*i +: 4] = bcd_reg[4*i +: 4] + 4'd3;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle_load;
      channel <= 1'b0;
      iter <= '0;
      bcd_valid <= 1'b0;
    end else begin
      bcd_valid <= 1'b0;
      case (state)
        idle_load: begin
          bin_reg <= channel ? count_2 : count_1;
          bcd_reg <= '0;
          iter <= '0;
          state <= shift;
        end
        shift: begin
          {bcd_reg, bin_reg} <= {bcd_adj, bin_reg} << 1;
          iter <= iter + 1'b1;
          if (iter == count_idx_w'(count_w - 1)) begin
            state <= done;
          end
        end
        done: begin
          bcd_valid <= 1'b1;
          bcd_channel <= channel;
          bcd_word <= bcd_reg;
          channel <= ~channel;
          state <= idle_load;
        end
        default: state <= idle_load;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: digit_scanner.sv
`default_nettype none

module digit_scanner
  import display_pkg::*;
(
  input  wire            clk,
  input  wire            reset,
  input  wire            bcd_valid,
  input  wire            bcd_channel,
  input  wire bcd_word_t bcd_word,
  output logic           frame_valid,
  output sel_t           frame_sel,
  output seg_t           frame_seg
);

  bcd_t [num_digits-1:0] digits;
  logic [scan_cnt_w-1:0] timer;
  logic [digit_idx_w-1:0] index;
  logic frame_tick;

  assign frame_tick = (timer == scan_cnt_w'(scan_period - 1));

  // channel 0 owns digits 0 to 3, channel 1 owns digits 4 to 7.
  always_ff @(posedge clk) begin
    if (reset) begin
      digits <= '0;
    end else if (bcd_valid) begin
      if (bcd_channel) begin
        digits[num_digits-1:digits_per_channel] <= bcd_word;
      end else begin
        digits[digits_per_channel-1:0] <= bcd_word;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      timer <= '0;
      index <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= frame_tick;
      if (frame_tick) begin
        timer <= '0;
        if (index == digit_idx_w'(num_digits - 1)) begin
          index <= '0;
        end else begin
          index <= index + 1'b1;
        end
      end else begin
        timer <= timer + 1'b1;
      end
    end
  end

  // the frame shows the digit at the current index, before it advances.
  always_ff @(posedge clk) begin
    if (frame_tick) begin
      frame_sel <= sel_t'(1) << index;
      frame_seg <= seg_font[digits[index]];
    end
  end

endmodule

`default_nettype wire

// File: hc595_driver.sv
`default_nettype none

module hc595_driver
  import display_pkg::*;
(
  input  wire       clk,
  input  wire       reset,
  input  wire       frame_valid,
  input  wire sel_t frame_sel,
  input  wire seg_t frame_seg,
  output logic      sck,
  output logic      rck,
  output logic      ser
);

  typedef enum logic [1:0] {idle, shift_low, shift_high, latch} state_t;

  state_t state;
  logic [frame_bits-1:0] frame;
  logic [frame_bits-1:0] shreg;
  logic [frame_idx_w-1:0] bit_cnt;
  logic [sck_cnt_w-1:0] half_cnt;
  logic half_end;

  // select byte goes out first so it lands in the far register of the chain.
  assign frame = {frame_sel, frame_seg};
  assign half_end = (half_cnt == sck_cnt_w'(sck_half - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      bit_cnt <= '0;
      half_cnt <= '0;
      sck <= 1'b0;
      rck <= 1'b0;
      ser <= 1'b0;
    end else begin
      rck <= 1'b0;
      case (state)
        idle: begin
          if (frame_valid) begin
            shreg <= frame;
            ser <= frame[frame_bits-1];
            bit_cnt <= '0;
            half_cnt <= '0;
            state <= shift_low;
          end
        end
        shift_low: begin
          if (half_end) begin
            half_cnt <= '0;
            sck <= 1'b1;
            state <= shift_high;
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        shift_high: begin
          if (half_end) begin
            half_cnt <= '0;
            sck <= 1'b0;
            if (bit_cnt == frame_idx_w'(frame_bits - 1)) begin
              ser <= 1'b0;
              rck <= 1'b1;
              state <= latch;
            end else begin
              // next bit is set up on the falling edge of sck.
              ser <= shreg[frame_bits-2];
              shreg <= shreg << 1;
              bit_cnt <= bit_cnt + 1'b1;
              state <= shift_low;
            end
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        latch: state <= idle;
        default: state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: encoder_display_top.sv
`default_nettype none

module encoder_display_top
  import encoder_pkg::*;
  import display_pkg::*;
(
  input  wire    clk,
  input  wire    reset,
  input  wire    a_1,
  input  wire    b_1,
  input  wire    a_2,
  input  wire    b_2,
  input  wire    clear_1,
  input  wire    clear_2,
  output logic   sck,
  output logic   rck,
  output logic   ser,
  output count_t cnt_1,
  output count_t cnt_2
);

  logic bcd_valid;
  logic bcd_channel;
  bcd_word_t bcd_word;
  logic frame_valid;
  sel_t frame_sel;
  seg_t frame_seg;

  quad_decoder quad_decoder_inst_1 (
    .clk(clk),
    .reset(reset),
    .a(a_1),
    .b(b_1),
    .clear(clear_1),
    .count(cnt_1)
  );

  quad_decoder quad_decoder_inst_2 (
    .clk(clk),
    .reset(reset),
    .a(a_2),
    .b(b_2),
    .clear(clear_2),
    .count(cnt_2)
  );

  bin_to_bcd bin_to_bcd_inst (
    .clk(clk),
    .reset(reset),
    .count_1(cnt_1),
    .count_2(cnt_2),
    .bcd_valid(bcd_valid),
    .bcd_channel(bcd_channel),
    .bcd_word(bcd_word)
  );

  digit_scanner digit_scanner_inst (
    .clk(clk),
    .reset(reset),
    .bcd_valid(bcd_valid),
    .bcd_channel(bcd_channel),
    .bcd_word(bcd_word),
    .frame_valid(frame_valid),
    .frame_sel(frame_sel),
    .frame_seg(frame_seg)
  );

  hc595_driver hc595_driver_inst (
    .clk(clk),
    .reset(reset),
    .frame_valid(frame_valid),
    .frame_sel(frame_sel),
    .frame_seg(frame_seg),
    .sck(sck),
    .rck(rck),
    .ser(ser)
  );

endmodule

`default_nettype wire

// File: encoder_display_tb.sv
`default_nettype none

module encoder_display_tb
  import encoder_pkg::*;
  import display_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic clk;
  logic reset;
  logic a_1;
  logic b_1;
  logic a_2;
  logic b_2;
  logic clear_1;
  logic clear_2;
  logic sck;
  logic rck;
  logic ser;
  count_t cnt_1;
  count_t cnt_2;

  int mismatch_count;
  int fault_count;
  int exp_count [2];
  int phase_idx [2];
  logic [frame_bits-1:0] frames_q [$];
  logic [frame_bits-1:0] shift_in;
  int sck_rises;
  logic sck_prev;
  logic rck_prev;

  encoder_display_top i_dut (
    .clk(clk),
    .reset(reset),
    .a_1(a_1),
    .b_1(b_1),
    .a_2(a_2),
    .b_2(b_2),
    .clear_1(clear_1),
    .clear_2(clear_2),
    .sck(sck),
    .rck(rck),
    .ser(ser),
    .cnt_1(cnt_1),
    .cnt_2(cnt_2)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("[FAIL] %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
      mismatch_count++;
    end
  endtask

  // forward order with A leading B.
  function automatic logic [1:0] gray_phase(input int idx);
    case (idx)
      0: return 2'b00;
      1: return 2'b10;
      2: return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  task automatic hold_random();
    int hold;
    hold = 4 + int'($urandom % 5);
    repeat (hold) @(negedge clk);
  endtask

  task automatic move_phase(input int ch, input int up);
    phase_idx[ch] = (up != 0) ? (phase_idx[ch] + 1) % 4 : (phase_idx[ch] + 3) % 4;
    if (ch == 0) begin
      {a_1, b_1} = gray_phase(phase_idx[ch]);
    end else begin
      {a_2, b_2} = gray_phase(phase_idx[ch]);
    end
    hold_random();
  endtask

  task automatic pulse_clear(input int ch);
    if (ch == 0) begin
      clear_1 = 1'b1;
    end else begin
      clear_2 = 1'b1;
    end
    hold_random();
    clear_1 = 1'b0;
    clear_2 = 1'b0;
    hold_random();
  endtask

  // frames are read on the rising edge, the monitor writes them on the falling edge.
  task automatic check_display();
    int mark;
    int waited;
    int idx;
    int value;
    logic [frame_bits-1:0] fr;
    sel_t seen;
    seen = '0;
    waited = 0;
    @(posedge clk);
    mark = frames_q.size();
    while (frames_q.size() < mark + num_digits && waited < 1000) begin
      @(posedge clk);
      waited++;
    end
    if (frames_q.size() < mark + num_digits) begin
      $display("timeout: no full scan of %0d display frames within 1000 cycles", num_digits);
      fault_count++;
    end else begin
      for (int k = 0; k < num_digits; k++) begin
        fr = frames_q[mark + k];
        check_value("frame_sel set bits", 1, $countones(fr[15:8]));
        idx = 0;
        for (int n = 0; n < num_digits; n++) begin
          if (fr[8 + n]) begin
            idx = n;
          end
        end
        seen = seen | fr[15:8];
        value = exp_count[idx / digits_per_channel];
        repeat (idx % digits_per_channel) value = value / 10;
        check_value("frame_seg", int'(seg_font[value % 10]), int'(fr[7:0]));
      end
      check_value("frame_sel digits seen", 8'hff, int'(seen));
    end
    @(negedge clk);
  endtask

  // counts settle 3 cycles after an input change, the buffer within about 50.
  task automatic check_counts_and_display();
    repeat (4) @(negedge clk);
    check_value("cnt_1", exp_count[0], int'(cnt_1));
    check_value("cnt_2", exp_count[1], int'(cnt_2));
    repeat (100) @(negedge clk);
    check_display();
  endtask

  always @(negedge clk) begin
    if (reset) begin
      shift_in = '0;
      sck_rises = 0;
      sck_prev = 1'b0;
      rck_prev = 1'b0;
    end else begin
      if (sck && !sck_prev) begin
        shift_in = {shift_in[frame_bits-2:0], ser};
        sck_rises++;
      end
      if (rck && !rck_prev) begin
        check_value("sck rises per frame", frame_bits, sck_rises);
        frames_q.push_back(shift_in);
        sck_rises = 0;
      end
      if (rck && rck_prev) begin
        $display("rck stayed high for more than one cycle at %0d ns", $time);
        fault_count++;
      end
      sck_prev = sck;
      rck_prev = rck;
    end
  end

  initial begin
    int fd;
    int ch;
    int dir;
    int steps;
    int clr;
    int expected;
    string header;
    clk = 1'b0;
    reset = 1'b1;
    a_1 = 1'b0;
    b_1 = 1'b0;
    a_2 = 1'b0;
    b_2 = 1'b0;
    clear_1 = 1'b0;
    clear_2 = 1'b0;
    mismatch_count = 0;
    fault_count = 0;
    exp_count = '{0, 0};
    phase_idx = '{0, 0};
    void'($urandom(83));
    repeat (16) @(negedge clk);
    reset = 1'b0;
    check_counts_and_display();
    fd = $fopen("encoder_display_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open encoder_display_testdata.txt for reading");
      fault_count++;
    end else begin
      void'($fgets(header, fd));
      while ($fscanf(fd, "%d %d %d %d %d\n", ch, dir, steps, clr, expected) == 5) begin
        if (clr != 0) begin
          pulse_clear(ch - 1);
        end
        repeat (steps) move_phase(ch - 1, dir);
        exp_count[ch - 1] = expected;
        check_counts_and_display();
      end
      $fclose(fd);
    end
    $display("mismatches: %0d, other failures: %0d", mismatch_count, fault_count);
    if (mismatch_count == 0 && fault_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: encoder_display_testdata.txt
# channel(1/2) direction(1 up, 0 down) steps clear(1 = pulse first) expected_count
1 1 6 0 6
1 0 2 0 4
2 0 1 0 9999
2 1 1 0 0
2 0 3 0 9997
1 1 9 0 13
2 1 5 0 2
1 0 0 1 0
1 0 1 0 9999
1 1 2 0 1
2 0 0 1 0
2 1 7 0 7
1 0 4 0 9997
2 0 0 1 0
1 1 3 0 0

// File: compile.f
encoder_pkg.sv
display_pkg.sv
quad_decoder.sv
bin_to_bcd.sv
digit_scanner.sv
hc595_driver.sv
encoder_display_top.sv
encoder_display_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= encoder_display_tb
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
